// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f tb.f --top-module tb_top -o Vtb_top

run: build
	./obj_dir/Vtb_top | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_top

clean:
	rm -rf obj_dir sim.log

// File: design/bus_pkg.sv
`default_nettype none

`include "core_params.svh"

package bus_pkg;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
    } mem_req_t;

    // Read data comes back exactly one cycle after the granted read
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic {
        OWN_FETCH,
        OWN_DATA
    } owner_t;

endpackage

`default_nettype wire

// File: design/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of the datapath, of addresses and of a memory word
`define CORE_XLEN 32

// Architectural integer registers including the hard-wired r0
`define CORE_NREGS 32

// Address of the first instruction fetched after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: design/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

    // =========================================================================
    // Encodings
    // =========================================================================
    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI,
        OP_LU12I, OP_LD, OP_ST, OP_BEQ, OP_BNE, OP_B
    } op_t;

    typedef enum logic [1:0] {
        FS_REQ,                                 // Read request out, waiting for a grant
        FS_WAIT,                                // Read granted, response due this cycle
        FS_HOLD                                 // Word captured, decode not ready yet
    } fetch_state_t;

    // =========================================================================
    // Stage bundles
    // =========================================================================
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        op_t                   op;
        logic [`CORE_XLEN-1:0] opnd_a;
        logic [`CORE_XLEN-1:0] opnd_b;         // Register value or immediate
        logic [`CORE_XLEN-1:0] st_data;
        logic [4:0]            dest;
        logic                  we;             // Never set for r0
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [4:0]            dest;
        logic [`CORE_XLEN-1:0] value;
        logic                  is_load;        // Value not known until writeback
    } fwd_t;

    typedef struct packed {
        logic                  taken;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [4:0]            dest;
        logic [`CORE_XLEN-1:0] value;
    } wb_trace_t;

endpackage

`default_nettype wire

// File: design/core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module core_top (
    input  wire                    clk,
    input  wire                    arst_n,
    output bus_pkg::mem_req_t      mem_req,
    input  wire bus_pkg::mem_rsp_t mem_rsp,
    output core_pkg::wb_trace_t    trace
);

    import core_pkg::*;
    import bus_pkg::*;

    mem_req_t              fetch_req;
    mem_req_t              data_req;
    mem_rsp_t              fetch_rsp;
    mem_rsp_t              data_rsp;
    logic                  fetch_grant;
    logic                  data_grant;
    logic                  if_valid;
    if_id_t                if_data;
    logic                  id_allow_in;
    logic                  id_valid;
    id_ex_t                id_data;
    logic                  ex_allow_in;
    redirect_t             redirect;
    fwd_t                  ex_fwd;
    fwd_t                  wb_fwd;
    logic [4:0]            raddr1;
    logic [4:0]            raddr2;
    logic [`CORE_XLEN-1:0] rdata1;
    logic [`CORE_XLEN-1:0] rdata2;
    logic                  wr_en;
    logic [4:0]            wr_addr;
    logic [`CORE_XLEN-1:0] wr_data;

    fetch_stage u_fetch (
        .clk,
        .arst_n,
        .redirect,
        .id_allow_in,
        .req      (fetch_req),
        .grant    (fetch_grant),
        .rsp      (fetch_rsp),
        .if_valid,
        .if_data
    );

    decode_stage u_decode (
        .clk,
        .arst_n,
        .if_valid,
        .if_data,
        .allow_in (id_allow_in),
        .ex_allow_in,
        .id_valid,
        .id_data,
        .redirect,
        .raddr1,
        .raddr2,
        .rdata1,
        .rdata2,
        .ex_fwd,
        .wb_fwd
    );

    exec_stage u_exec (
        .clk,
        .arst_n,
        .id_valid,
        .id_data,
        .allow_in (ex_allow_in),
        .req      (data_req),
        .grant    (data_grant),
        .rsp      (data_rsp),
        .ex_fwd,
        .wb_fwd,
        .wr_en,
        .wr_addr,
        .wr_data,
        .trace
    );

    reg_file u_rf (
        .clk,
        .arst_n,
        .raddr1,
        .raddr2,
        .rdata1,
        .rdata2,
        .wr_en,
        .wr_addr,
        .wr_data
    );

    mem_arbiter u_arb (
        .clk,
        .arst_n,
        .fetch_req,
        .data_req,
        .fetch_grant,
        .data_grant,
        .mem_req,
        .mem_rsp,
        .fetch_rsp,
        .data_rsp
    );

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module decode_stage (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   if_valid,
    input  wire core_pkg::if_id_t if_data,
    output logic                  allow_in,
    input  wire                   ex_allow_in,
    output logic                  id_valid,
    output core_pkg::id_ex_t      id_data,
    output core_pkg::redirect_t   redirect,
    output logic [4:0]            raddr1,
    output logic [4:0]            raddr2,
    input  wire [`CORE_XLEN-1:0]  rdata1,
    input  wire [`CORE_XLEN-1:0]  rdata2,
    input  wire core_pkg::fwd_t   ex_fwd,
    input  wire core_pkg::fwd_t   wb_fwd
);

    import core_pkg::*;

    logic                  valid_r;
    if_id_t                if_r;
    logic [`CORE_XLEN-1:0] inst;
    op_t                   op;
    logic [4:0]            rd;
    logic [4:0]            rj;
    logic [4:0]            rk;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] br_offs;
    logic [`CORE_XLEN-1:0] src1;
    logic [`CORE_XLEN-1:0] src2;
    logic                  use_rj;
    logic                  use_r2;
    logic                  writes_rd;
    logic                  stall;
    logic                  src_eq;

    // Younger stage wins, the register file is the fallback
    function automatic logic [`CORE_XLEN-1:0] operand(
        input logic [4:0]            addr,
        input logic [`CORE_XLEN-1:0] rf_value,
        input fwd_t                  ex,
        input fwd_t                  wb
    );
        logic [`CORE_XLEN-1:0] value;
        if (ex.valid && ex.dest == addr) begin
            value = ex.value;
        end else if (wb.valid && wb.dest == addr) begin
            value = wb.value;
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    // =========================================================================
    // Fields and opcode
    // =========================================================================
    assign inst = if_r.instr;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    always_comb begin
        casez (inst[31:15])
            17'b000000_0000_01_00000: op = OP_ADD;
            17'b000000_0000_01_00010: op = OP_SUB;
            17'b000000_0000_01_01001: op = OP_AND;
            17'b000000_0000_01_01010: op = OP_OR;
            17'b000000_0000_01_01011: op = OP_XOR;
            17'b000000_1010_???????:  op = OP_ADDI;
            17'b0001010_??????????:   op = OP_LU12I;
            17'b001010_0010_???????:  op = OP_LD;
            17'b001010_0110_???????:  op = OP_ST;
            17'b010110_???????????:   op = OP_BEQ;
            17'b010111_???????????:   op = OP_BNE;
            17'b010100_???????????:   op = OP_B;
            default:                  op = OP_NOP;
        endcase
    end

    assign use_rj    = !(op inside {OP_NOP, OP_LU12I, OP_B});
    assign use_r2    = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ST, OP_BEQ, OP_BNE};
    assign writes_rd = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LU12I, OP_LD};

    assign imm     = (op == OP_LU12I) ? {inst[24:5], 12'b0} : {{20{inst[21]}}, inst[21:10]};
    assign br_offs = (op == OP_B) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                  : {{14{inst[25]}}, inst[25:10], 2'b0};

    // =========================================================================
    // Operands, hazards and branches
    // =========================================================================
    assign raddr1 = rj;
    assign raddr2 = (op inside {OP_ST, OP_BEQ, OP_BNE}) ? rd : rk;
    assign src1   = operand(raddr1, rdata1, ex_fwd, wb_fwd);
    assign src2   = operand(raddr2, rdata2, ex_fwd, wb_fwd);

    assign stall = ex_fwd.valid && ex_fwd.is_load &&
                   ((use_rj && ex_fwd.dest == raddr1) || (use_r2 && ex_fwd.dest == raddr2));

    assign allow_in = !valid_r || (!stall && ex_allow_in);
    assign id_valid = valid_r && !stall;
    assign src_eq   = (src1 == src2);

    assign redirect = '{
        taken:  valid_r && !stall && ((op == OP_B) || (op == OP_BEQ && src_eq) ||
                                      (op == OP_BNE && !src_eq)),
        target: if_r.pc + br_offs
    };

    assign id_data = '{
        pc:      if_r.pc,
        op:      op,
        opnd_a:  src1,
        opnd_b:  (op inside {OP_ADDI, OP_LU12I, OP_LD, OP_ST}) ? imm : src2,
        st_data: src2,
        dest:    rd,
        we:      writes_rd && (rd != 5'd0)
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_r <= 1'b0;
        end else if (redirect.taken) begin
            valid_r <= 1'b0;                    // Drops the wrong-path word arriving now
        end else if (allow_in) begin
            valid_r <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && allow_in) begin
            if_r <= if_data;
        end
    end

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module exec_stage (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    id_valid,
    input  wire core_pkg::id_ex_t  id_data,
    output logic                   allow_in,
    output bus_pkg::mem_req_t      req,
    input  wire                    grant,
    input  wire bus_pkg::mem_rsp_t rsp,
    output core_pkg::fwd_t         ex_fwd,
    output core_pkg::fwd_t         wb_fwd,
    output logic                   wr_en,
    output logic [4:0]             wr_addr,
    output logic [`CORE_XLEN-1:0]  wr_data,
    output core_pkg::wb_trace_t    trace
);

    import core_pkg::*;

    logic                  ex_valid;
    id_ex_t                ex_r;
    logic [`CORE_XLEN-1:0] alu_res;
    logic                  is_ld;
    logic                  is_st;
    logic                  wb_valid;
    logic                  wb_pend;
    logic                  wb_we;
    logic                  wb_ready_go;
    logic                  wb_allow_in;
    logic [`CORE_XLEN-1:0] wb_pc;
    logic [`CORE_XLEN-1:0] wb_res;
    logic [4:0]            wb_dest;

    // =========================================================================
    // Execute
    // =========================================================================
    always_comb begin
        case (ex_r.op)
            OP_ADD, OP_ADDI, OP_LD, OP_ST: alu_res = ex_r.opnd_a + ex_r.opnd_b;
            OP_SUB:   alu_res = ex_r.opnd_a - ex_r.opnd_b;
            OP_AND:   alu_res = ex_r.opnd_a & ex_r.opnd_b;
            OP_OR:    alu_res = ex_r.opnd_a | ex_r.opnd_b;
            OP_XOR:   alu_res = ex_r.opnd_a ^ ex_r.opnd_b;
            OP_LU12I: alu_res = ex_r.opnd_b;
            default:  alu_res = '0;
        endcase
    end

    assign is_ld = (ex_r.op == OP_LD);
    assign is_st = (ex_r.op == OP_ST);

    assign wb_ready_go = !wb_pend || rsp.valid;
    assign wb_allow_in = !wb_valid || wb_ready_go;
    assign allow_in    = !ex_valid || wb_allow_in;

    // Issued only in the cycle the instruction leaves execute
    assign req = '{
        valid: ex_valid && (is_ld || is_st) && wb_allow_in,
        write: is_st,
        addr:  alu_res,
        wdata: ex_r.st_data
    };

    assign ex_fwd = '{valid: ex_valid && ex_r.we, dest: ex_r.dest, value: alu_res, is_load: is_ld};

    // =========================================================================
    // Writeback
    // =========================================================================
    assign wr_en   = wb_valid && wb_ready_go && wb_we;
    assign wr_addr = wb_dest;
    assign wr_data = wb_pend ? rsp.rdata : wb_res;
    assign wb_fwd  = '{valid: wb_valid && wb_we, dest: wb_dest, value: wr_data, is_load: wb_pend};
    assign trace   = '{valid: wr_en, pc: wb_pc, dest: wb_dest, value: wr_data};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
            wb_pend  <= 1'b0;
        end else begin
            if (allow_in) begin
                ex_valid <= id_valid;
            end
            if (wb_allow_in) begin
                wb_valid <= ex_valid;
                wb_pend  <= ex_valid && is_ld && grant;  // Read data lands next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && allow_in) begin
            ex_r <= id_data;
        end
        if (ex_valid && wb_allow_in) begin
            wb_pc   <= ex_r.pc;
            wb_dest <= ex_r.dest;
            wb_we   <= ex_r.we;
            wb_res  <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module fetch_stage (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire core_pkg::redirect_t redirect,
    input  wire                 id_allow_in,
    output bus_pkg::mem_req_t   req,
    input  wire                 grant,
    input  wire bus_pkg::mem_rsp_t rsp,
    output logic                if_valid,
    output core_pkg::if_id_t    if_data
);

    import core_pkg::*;

    fetch_state_t          state;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] hold_word;
    logic                  flush;
    logic                  fetch_en;
    logic                  deliver;

    assign deliver  = (state == FS_WAIT) && rsp.valid && !flush;  // Fresh word on the bus
    assign if_valid = deliver || (state == FS_HOLD);
    assign if_data  = '{pc: pc, instr: (state == FS_HOLD) ? hold_word : rsp.rdata};
    assign req      = '{valid: fetch_en && (state == FS_REQ), write: 1'b0, addr: pc, wdata: '0};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= FS_REQ;
            pc       <= `CORE_RESET_PC;
            flush    <= 1'b0;
            fetch_en <= 1'b0;                   // Keeps the bus quiet for the first cycle
        end else begin
            fetch_en <= 1'b1;
            if (redirect.taken) begin
                pc    <= redirect.target;
                flush <= (state == FS_REQ) && grant;  // Stale read already on its way
                state <= ((state == FS_REQ) && grant) ? FS_WAIT : FS_REQ;
            end else begin
                case (state)
                    FS_REQ: begin
                        if (grant) begin
                            state <= FS_WAIT;
                        end
                    end
                    FS_WAIT: begin
                        if (rsp.valid) begin
                            flush <= 1'b0;
                            state <= (flush || id_allow_in) ? FS_REQ : FS_HOLD;
                            if (deliver && id_allow_in) begin
                                pc <= pc + 32'd4;
                            end
                        end
                    end
                    FS_HOLD: begin
                        if (id_allow_in) begin
                            state <= FS_REQ;
                            pc    <= pc + 32'd4;
                        end
                    end
                    default: state <= FS_REQ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deliver && !id_allow_in) begin
            hold_word <= rsp.rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire bus_pkg::mem_req_t fetch_req,
    input  wire bus_pkg::mem_req_t data_req,
    output logic                   fetch_grant,
    output logic                   data_grant,
    output bus_pkg::mem_req_t      mem_req,
    input  wire bus_pkg::mem_rsp_t mem_rsp,
    output bus_pkg::mem_rsp_t      fetch_rsp,
    output bus_pkg::mem_rsp_t      data_rsp
);

    import bus_pkg::*;

    owner_t rd_owner;

    assign data_grant  = data_req.valid;                      // Data side always wins
    assign fetch_grant = fetch_req.valid && !data_req.valid;
    assign mem_req     = data_req.valid ? data_req : fetch_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_owner <= OWN_FETCH;
        end else if (mem_req.valid && !mem_req.write) begin
            rd_owner <= data_grant ? OWN_DATA : OWN_FETCH;
        end
    end

    assign fetch_rsp = '{valid: mem_rsp.valid && (rd_owner == OWN_FETCH), rdata: mem_rsp.rdata};
    assign data_rsp  = '{valid: mem_rsp.valid && (rd_owner == OWN_DATA), rdata: mem_rsp.rdata};

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module reg_file (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire [4:0]             raddr1,
    input  wire [4:0]             raddr2,
    output logic [`CORE_XLEN-1:0] rdata1,
    output logic [`CORE_XLEN-1:0] rdata2,
    input  wire                   wr_en,
    input  wire [4:0]             wr_addr,
    input  wire [`CORE_XLEN-1:0]  wr_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Old value on a same-cycle write, decode forwards the new one
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/core_pkg.sv
design/bus_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/reg_file.sv
design/mem_arbiter.sv
design/core_top.sv
verif/tb_top.sv

// File: verif/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module tb_top;

    import core_pkg::*;
    import bus_pkg::*;

    localparam int PROG_LEN  = 200;
    localparam int MEM_WORDS = 1024;
    localparam int DATA_BASE = 256;                 // Word index of the load/store region
    localparam int DATA_LEN  = 64;
    localparam int LIMIT     = PROG_LEN * 8 + 200;
    localparam logic [31:0] LOOP_PC = (PROG_LEN - 1) * 4;

    logic      clk;
    logic      arst_n;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;
    wb_trace_t trace;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] model_regs [`CORE_NREGS];
    op_t         kind [PROG_LEN];
    logic [4:0]  f_rd [PROG_LEN];
    logic [4:0]  f_rj [PROG_LEN];
    logic [4:0]  f_rk [PROG_LEN];
    logic [31:0] f_imm [PROG_LEN];
    wb_trace_t   exp_q [$];
    logic [31:0] lfsr;
    int          cycles;
    int          loop_fetches;
    logic        seen_req;

    core_top u_dut (
        .clk,
        .arst_n,
        .mem_req,
        .mem_rsp,
        .trace
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // Memory model
    // ========================================================================
    always @(posedge clk) begin
        if (mem_req.valid && mem_req.write) begin
            mem[mem_req.addr[11:2]] <= mem_req.wdata;
        end
        mem_rsp <= '{valid: mem_req.valid && !mem_req.write, rdata: mem[mem_req.addr[11:2]]};
    end

    // ========================================================================
    // Random numbers and program generation
    // ========================================================================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Most picks land in r0 to r4 so that hazards are frequent
    function automatic logic [4:0] pick_reg();
        logic [31:0] v;
        v = rand_bits(3);
        if (v >= 5) begin
            v = rand_bits(5);
        end
        return v[4:0];
    endfunction

    task automatic gen_program();
        logic [31:0] sel;
        logic [31:0] val;
        logic [15:0] offs;
        logic [11:0] off12;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            sel = rand_bits(4);
            rd = pick_reg();
            rj = pick_reg();
            rk = pick_reg();
            offs = 16'(1 + rand_bits(2));
            if (i + offs > PROG_LEN - 1) begin
                offs = 16'(PROG_LEN - 1 - i);      // Never past the final loop
            end
            off12 = 12'(DATA_BASE * 4 + 4 * rand_bits(6));
            case (sel)
                0, 1, 2, 3, 4, 5: begin
                    kind[i] = (sel == 2) ? OP_SUB : (sel == 3) ? OP_AND :
                              (sel == 4) ? OP_OR : (sel == 5) ? OP_XOR : OP_ADD;
                    val = (sel == 2) ? 32'h0011_0000 : (sel == 3) ? 32'h0014_8000 :
                          (sel == 4) ? 32'h0015_0000 : (sel == 5) ? 32'h0015_8000 : 32'h0010_0000;
                    mem[i] = val | {17'b0, rk, rj, rd};
                end
                6, 7: begin
                    kind[i] = OP_ADDI;
                    val = rand_bits(12);
                    f_imm[i] = {{20{val[11]}}, val[11:0]};
                    mem[i] = 32'h0280_0000 | {10'b0, val[11:0], rj, rd};
                end
                8: begin
                    kind[i] = OP_LU12I;
                    val = rand_bits(20);
                    f_imm[i] = {val[19:0], 12'b0};
                    mem[i] = 32'h1400_0000 | {7'b0, val[19:0], rd};
                end
                9, 10, 11, 12: begin
                    kind[i] = (sel < 11) ? OP_LD : OP_ST;
                    rj = 5'd0;                      // Absolute address in the data region
                    f_imm[i] = {20'b0, off12};
                    mem[i] = ((sel < 11) ? 32'h2880_0000 : 32'h2980_0000) |
                             {10'b0, off12, 5'd0, rd};
                end
                13, 14: begin
                    kind[i] = (sel == 13) ? OP_BEQ : OP_BNE;
                    f_imm[i] = {14'b0, offs, 2'b0};
                    mem[i] = ((sel == 13) ? 32'h5800_0000 : 32'h5C00_0000) |
                             {6'b0, offs, rj, rd};
                end
                default: begin
                    kind[i] = OP_B;
                    f_imm[i] = {14'b0, offs, 2'b0};
                    mem[i] = 32'h5000_0000 | {6'b0, offs, 10'b0};
                end
            endcase
            f_rd[i] = rd;
            f_rj[i] = rj;
            f_rk[i] = rk;
        end
        kind[PROG_LEN-1] = OP_B;
        f_imm[PROG_LEN-1] = '0;
        mem[PROG_LEN-1] = 32'h5000_0000;            // b 0
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] res;
        logic [31:0] a;
        logic [31:0] b;
        int          idx;
        logic        wr;
        wb_trace_t   rec;
        pc = `CORE_RESET_PC;
        for (int r = 0; r < `CORE_NREGS; r++) begin
            model_regs[r] = '0;
        end
        for (int s = 0; s < 4 * PROG_LEN; s++) begin
            idx = int'(pc >> 2);
            if (idx == PROG_LEN - 1) begin
                break;
            end
            a = model_regs[f_rj[idx]];
            b = model_regs[f_rk[idx]];
            wr = 1'b1;
            res = '0;
            pc = pc + 4;
            case (kind[idx])
                OP_ADD:   res = a + b;
                OP_SUB:   res = a - b;
                OP_AND:   res = a & b;
                OP_OR:    res = a | b;
                OP_XOR:   res = a ^ b;
                OP_ADDI:  res = a + f_imm[idx];
                OP_LU12I: res = f_imm[idx];
                OP_LD:    res = model_mem[(a + f_imm[idx]) >> 2];
                OP_ST: begin
                    wr = 1'b0;
                    model_mem[(a + f_imm[idx]) >> 2] = model_regs[f_rd[idx]];
                end
                default: begin
                    wr = 1'b0;
                    if (kind[idx] == OP_B ||
                        (kind[idx] == OP_BEQ && a == model_regs[f_rd[idx]]) ||
                        (kind[idx] == OP_BNE && a != model_regs[f_rd[idx]])) begin
                        pc = 32'(idx * 4) + f_imm[idx];
                    end
                end
            endcase
            if (wr && f_rd[idx] != 5'd0) begin
                model_regs[f_rd[idx]] = res;
                rec = '{valid: 1'b1, pc: 32'(idx * 4), dest: f_rd[idx], value: res};
                exp_q.push_back(rec);
            end
        end
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic report_failure();
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_trace(input wb_trace_t got, input wb_trace_t exp);
        if (got !== exp) begin
            $display("error %0t: retire pc %h r%0d = %h, expected pc %h r%0d = %h", $time,
                     got.pc, got.dest, got.value, exp.pc, exp.dest, exp.value);
            report_failure();
        end
    endtask

    task automatic compare_word(input int idx, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %0t: memory word %h holds %h, expected %h", $time,
                     idx * 4, got, exp);
            report_failure();
        end
    endtask

    task automatic compare_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("error %0t: first request addr %h write %b, expected addr %h read",
                     $time, got.addr, got.write, exp.addr);
            report_failure();
        end
    endtask

    always @(negedge clk) begin
        if ((!arst_n || !seen_req) && trace.valid) begin
            $display("a register write retired before the first fetch at time %0t", $time);
            report_failure();
        end else if (!arst_n && mem_req.valid) begin
            $display("a memory request was raised during reset at time %0t", $time);
            report_failure();
        end else if (arst_n && mem_req.valid && !seen_req) begin
            seen_req = 1'b1;
            compare_req(mem_req, '{valid: 1'b1, write: 1'b0, addr: `CORE_RESET_PC, wdata: '0});
        end
        if (arst_n && trace.valid) begin
            if (exp_q.size() == 0) begin
                $display("pc %h retired after every expected write was seen", trace.pc);
                report_failure();
            end else begin
                compare_trace(trace, exp_q.pop_front());
            end
        end
        if (mem_req.valid && !mem_req.write && mem_req.addr == LOOP_PC) begin
            loop_fetches++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, %0d register writes never retired",
                     cycles, exp_q.size());
            report_failure();
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        arst_n = 1'b0;
        mem_rsp = '0;
        lfsr = 32'h10e1;
        cycles = 0;
        loop_fetches = 0;
        seen_req = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9E37_79B1) ^ 32'h00C0_FFEE;
        end
        gen_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = mem[i];
        end
        run_model();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        while (exp_q.size() != 0 || loop_fetches < 2) begin
            @(posedge clk);
        end
        for (int i = DATA_BASE; i < DATA_BASE + DATA_LEN; i++) begin
            compare_word(i, mem[i], model_mem[i]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
